// File: serial_pkg.sv
package serial_pkg;

   ////////////////////
   // widths
   ////////////////////
   localparam int WORD_W = 32;
   localparam int REG_N  = 8;
   localparam int APB_AW = 5;

   typedef logic [WORD_W-1:0] word_t;    // data word.
   typedef logic [2:0]        reg_idx_t; // register file index.
   typedef logic [4:0]        cnt_t;     // serial bit position.
   typedef logic [3:0]        op_code_t; // command opcode.

   localparam cnt_t CNT_LAST = 5'd31;    // last bit of a pass.

   // opcodes, 8 to 15 are reserved and trap.
   localparam op_code_t OP_ADD = 4'd0;
   localparam op_code_t OP_SUB = 4'd1;
   localparam op_code_t OP_AND = 4'd2;
   localparam op_code_t OP_OR  = 4'd3;
   localparam op_code_t OP_XOR = 4'd4;
   localparam op_code_t OP_SLT = 4'd5;  // signed, result 0 or 1.
   localparam op_code_t OP_SLL = 4'd6;
   localparam op_code_t OP_SRL = 4'd7;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_INIT,
      ST_RUN,
      ST_TRAP
   } ctl_state_t;

   typedef struct packed {
      op_code_t op;
      reg_idx_t rd;
      reg_idx_t rs1;
      reg_idx_t rs2;
   } cmd_t;

   // sequencer to alu and register file.
   typedef struct packed {
      cnt_t cnt;
      logic init;   // first stage pass.
      logic run;    // result pass.
      logic cnt_en;
      logic first;  // bit 0 of a pass.
      logic rd_en;  // write the result bit.
   } seq_ctl_t;

   ////////////////////
   // register map
   ////////////////////
   localparam logic [APB_AW-1:0] ADDR_CMD    = 5'h00;
   localparam logic [APB_AW-1:0] ADDR_STATUS = 5'h04;
   localparam logic [APB_AW-1:0] ADDR_CTRL   = 5'h08;
   localparam logic [APB_AW-1:0] ADDR_IDX    = 5'h0C;
   localparam logic [APB_AW-1:0] ADDR_DATA   = 5'h10;

endpackage

// File: serial_state.sv
`timescale 1ns/1ps

module serial_state (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  logic                 i_start,
   input  serial_pkg::cmd_t     i_cmd,
   input  logic                 i_sh_ready,
   output serial_pkg::seq_ctl_t o_ctl,
   output logic                 o_busy,
   output logic                 o_done,
   output logic                 o_trap
);

   serial_pkg::ctl_state_t state;
   serial_pkg::cnt_t       cnt;
   logic                   cnt_done;           // high on the last bit of a pass.
   logic                   stage_two_pending;  // init pass finished, run still to come.
   logic                   cnt_en;
   logic                   reserved_op;
   logic                   two_stage_op;

   assign reserved_op = i_cmd.op[3];  // 8 to 15.

   // slt needs the init pass for the compare, shifts for buffer and shamt.
   assign two_stage_op = (i_cmd.op == serial_pkg::OP_SLT) |
                         (i_cmd.op == serial_pkg::OP_SLL) |
                         (i_cmd.op == serial_pkg::OP_SRL);

   assign cnt_en = (state != serial_pkg::ST_IDLE);

   ////////////////////
   // control to datapath
   ////////////////////
   assign o_ctl.cnt    = cnt;
   assign o_ctl.init   = (state == serial_pkg::ST_INIT);
   assign o_ctl.run    = (state == serial_pkg::ST_RUN);
   assign o_ctl.cnt_en = cnt_en;
   assign o_ctl.first  = cnt_en & (cnt == '0);

   // only the run pass writes, so trap and init never touch rd.
   assign o_ctl.rd_en  = (state == serial_pkg::ST_RUN) & (i_cmd.rd != '0);

   // busy covers the hold cycle between passes and the final strobe.
   assign o_busy = cnt_en | stage_two_pending | o_done | o_trap;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state             <= serial_pkg::ST_IDLE;
         cnt               <= '0;
         cnt_done          <= 1'b0;
         stage_two_pending <= 1'b0;
         o_done            <= 1'b0;
         o_trap            <= 1'b0;
      end else begin
         cnt <= cnt + {4'd0, cnt_en};  // wraps to 0 at the end of a pass.

         // strobe built one cycle early from the counter.
         cnt_done <= cnt_en & (cnt == serial_pkg::CNT_LAST - 5'd1);

         o_done <= cnt_done & (state == serial_pkg::ST_RUN);
         o_trap <= cnt_done & (state == serial_pkg::ST_TRAP);

         if (cnt_en)
            stage_two_pending <= (state == serial_pkg::ST_INIT);

         case (state)
            serial_pkg::ST_IDLE: begin
               if (i_start) begin
                  if (reserved_op)
                     state <= serial_pkg::ST_TRAP;
                  else if (two_stage_op & !stage_two_pending)
                     state <= serial_pkg::ST_INIT;
                  else
                     state <= serial_pkg::ST_RUN;
               end else if (stage_two_pending & i_sh_ready) begin
                  state <= serial_pkg::ST_RUN;  // second stage after the hold cycle.
               end
            end
            default: begin
               if (cnt_done)
                  state <= serial_pkg::ST_IDLE;
            end
         endcase
      end
   end

endmodule

// File: serial_alu.sv
`timescale 1ns/1ps

module serial_alu (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  serial_pkg::seq_ctl_t i_ctl,
   input  serial_pkg::op_code_t i_op,
   input  logic                 i_rs1_bit,
   input  logic                 i_rs2_bit,
   output logic                 o_rd_bit,
   output logic                 o_sh_ready
);

   logic              is_sub;
   logic              op_b;
   logic              carry_q;
   logic              carry_in;
   logic              sum_bit;
   logic              carry_out;
   logic              last_bit;
   logic              lt_bit;
   logic              cmp_q;
   logic              slt_bit;
   serial_pkg::word_t sh_buf;
   serial_pkg::cnt_t  shamt;
   logic [5:0]        sll_pos;
   logic [5:0]        srl_pos;
   logic              sh_bit;

   ////////////////////
   // adder
   ////////////////////
   assign is_sub   = (i_op == serial_pkg::OP_SUB) | (i_op == serial_pkg::OP_SLT);
   assign op_b     = i_rs2_bit ^ is_sub;                  // invert rs2 to subtract.
   assign carry_in = i_ctl.first ? is_sub : carry_q;      // preset for the +1.
   assign sum_bit  = i_rs1_bit ^ op_b ^ carry_in;
   assign carry_out = (i_rs1_bit & op_b) | (i_rs1_bit & carry_in) | (op_b & carry_in);

   assign last_bit = (i_ctl.cnt == serial_pkg::CNT_LAST);

   // signed less than from the final borrow and the two sign bits.
   assign lt_bit  = ~carry_out ^ i_rs1_bit ^ i_rs2_bit;
   assign slt_bit = i_ctl.first & cmp_q;  // only bit 0 of the result is set.

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         carry_q    <= 1'b0;
         cmp_q      <= 1'b0;
         o_sh_ready <= 1'b0;
      end else begin
         if (i_ctl.cnt_en)
            carry_q <= carry_out;
         if (i_ctl.init & last_bit)
            cmp_q <= lt_bit;  // held over to the run pass.
         if (i_ctl.init & last_bit)
            o_sh_ready <= 1'b1;
         else if (i_ctl.run)
            o_sh_ready <= 1'b0;
      end
   end

   ////////////////////
   // shifter
   ////////////////////
   always_ff @(posedge i_clk) begin
      if (i_ctl.init) begin
         sh_buf <= {i_rs1_bit, sh_buf[serial_pkg::WORD_W-1:1]};  // lsb first.
         if (i_ctl.cnt < 5'd5)
            shamt[i_ctl.cnt[2:0]] <= i_rs2_bit;
      end
   end

   // bit 5 set means the source position falls outside the word.
   assign sll_pos = {1'b0, i_ctl.cnt} - {1'b0, shamt};
   assign srl_pos = {1'b0, i_ctl.cnt} + {1'b0, shamt};

   assign sh_bit = (i_op == serial_pkg::OP_SLL) ? (~sll_pos[5] & sh_buf[sll_pos[4:0]]) :
                                                   (~srl_pos[5] & sh_buf[srl_pos[4:0]]);

   always_comb begin
      case (i_op)
         serial_pkg::OP_ADD,
         serial_pkg::OP_SUB: o_rd_bit = sum_bit;
         serial_pkg::OP_AND: o_rd_bit = i_rs1_bit & i_rs2_bit;
         serial_pkg::OP_OR:  o_rd_bit = i_rs1_bit | i_rs2_bit;
         serial_pkg::OP_XOR: o_rd_bit = i_rs1_bit ^ i_rs2_bit;
         serial_pkg::OP_SLT: o_rd_bit = slt_bit;
         serial_pkg::OP_SLL,
         serial_pkg::OP_SRL: o_rd_bit = sh_bit;
         default:            o_rd_bit = 1'b0;
      endcase
   end

endmodule

// File: serial_rf.sv
`timescale 1ns/1ps

module serial_rf (
   input  logic                 i_clk,
   input  logic                 i_rst,
   input  serial_pkg::seq_ctl_t i_ctl,
   input  serial_pkg::reg_idx_t i_rs1,
   input  serial_pkg::reg_idx_t i_rs2,
   input  serial_pkg::reg_idx_t i_rd,
   input  logic                 i_rd_bit,
   output logic                 o_rs1_bit,
   output logic                 o_rs2_bit,
   input  serial_pkg::reg_idx_t i_host_idx,
   input  logic                 i_host_we,
   input  serial_pkg::word_t    i_host_wdata,
   output serial_pkg::word_t    o_host_rdata
);

   serial_pkg::word_t regs [serial_pkg::REG_N];
   logic              host_we;

   ////////////////////
   // serial ports
   ////////////////////
   // one bit per clock, the position follows the sequencer count.
   assign o_rs1_bit = regs[i_rs1][i_ctl.cnt];
   assign o_rs2_bit = regs[i_rs2][i_ctl.cnt];

   assign host_we = i_host_we & (i_host_idx != '0);  // entry 0 stays zero.

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         for (int i = 0; i < serial_pkg::REG_N; i++)
            regs[i] <= '0;
      end else begin
         // rd is written at the bit just read, so it may match a source.
         // the sequencer keeps rd_en low for register 0.
         if (i_ctl.rd_en)
            regs[i_rd][i_ctl.cnt] <= i_rd_bit;
         if (host_we)
            regs[i_host_idx] <= i_host_wdata;  // whole word.
      end
   end

   ////////////////////
   // host port
   ////////////////////
   assign o_host_rdata = regs[i_host_idx];

endmodule

// File: serial_apb_regs.sv
`timescale 1ns/1ps

module serial_apb_regs (
   input  logic                          i_clk,
   input  logic                          i_rst,
   input  logic                          i_psel,
   input  logic                          i_penable,
   input  logic                          i_pwrite,
   input  logic [serial_pkg::APB_AW-1:0] i_paddr,
   input  serial_pkg::word_t             i_pwdata,
   output serial_pkg::word_t             o_prdata,
   output logic                          o_pslverr,
   output logic                          o_irq,
   output logic                          o_start,
   output serial_pkg::cmd_t              o_cmd,
   input  logic                          i_busy,
   input  logic                          i_done,
   input  logic                          i_trap,
   output serial_pkg::reg_idx_t          o_host_idx,
   output logic                          o_host_we,
   output serial_pkg::word_t             o_host_wdata,
   input  serial_pkg::word_t             i_host_rdata
);

   logic             access;
   logic             hit_cmd;
   logic             hit_status;
   logic             hit_ctrl;
   logic             hit_idx;
   logic             hit_data;
   logic             unmapped;
   logic             busy_any;
   logic             wr_ok;
   logic             irq_en;
   logic             done_flag;
   logic             trap_flag;
   serial_pkg::cmd_t wr_cmd;

   ////////////////////
   // decode
   ////////////////////
   assign access     = i_psel & i_penable;  // zero wait, done in the access phase.
   assign hit_cmd    = (i_paddr == serial_pkg::ADDR_CMD);
   assign hit_status = (i_paddr == serial_pkg::ADDR_STATUS);
   assign hit_ctrl   = (i_paddr == serial_pkg::ADDR_CTRL);
   assign hit_idx    = (i_paddr == serial_pkg::ADDR_IDX);
   assign hit_data   = (i_paddr == serial_pkg::ADDR_DATA);
   assign unmapped   = ~(hit_cmd | hit_status | hit_ctrl | hit_idx | hit_data);

   assign busy_any = i_busy | o_start;  // covers the start cycle too.

   assign o_pslverr = access & (unmapped | (hit_cmd & i_pwrite & busy_any) |
                                (hit_data & busy_any));

   assign wr_ok = access & i_pwrite & ~o_pslverr;

   assign wr_cmd.op  = i_pwdata[3:0];
   assign wr_cmd.rd  = i_pwdata[6:4];
   assign wr_cmd.rs1 = i_pwdata[10:8];
   assign wr_cmd.rs2 = i_pwdata[14:12];

   assign o_host_we    = wr_ok & hit_data;
   assign o_host_wdata = i_pwdata;

   assign o_irq = done_flag & irq_en;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         o_start    <= 1'b0;
         o_cmd      <= '0;
         o_host_idx <= '0;
         irq_en     <= 1'b0;
         done_flag  <= 1'b0;
         trap_flag  <= 1'b0;
      end else begin
         o_start <= wr_ok & hit_cmd;  // one cycle pulse.
         if (wr_ok & hit_cmd)
            o_cmd <= wr_cmd;
         if (wr_ok & hit_ctrl)
            irq_en <= i_pwdata[0];
         if (wr_ok & hit_idx)
            o_host_idx <= i_pwdata[2:0];

         // write one to clear, a new pulse wins.
         if (wr_ok & hit_status & i_pwdata[1])
            done_flag <= 1'b0;
         if (i_done)
            done_flag <= 1'b1;
         if (wr_ok & hit_status & i_pwdata[2])
            trap_flag <= 1'b0;
         if (i_trap)
            trap_flag <= 1'b1;
      end
   end

   ////////////////////
   // read data
   ////////////////////
   always_comb begin
      o_prdata = '0;
      if (access & ~i_pwrite) begin
         case (i_paddr)
            serial_pkg::ADDR_CMD: begin
               o_prdata[3:0]   = o_cmd.op;
               o_prdata[6:4]   = o_cmd.rd;
               o_prdata[10:8]  = o_cmd.rs1;
               o_prdata[14:12] = o_cmd.rs2;
            end
            serial_pkg::ADDR_STATUS: o_prdata[2:0] = {trap_flag, done_flag, busy_any};
            serial_pkg::ADDR_CTRL:   o_prdata[0]   = irq_en;
            serial_pkg::ADDR_IDX:    o_prdata[2:0] = o_host_idx;
            serial_pkg::ADDR_DATA:   if (~busy_any) o_prdata = i_host_rdata;
            default:                 o_prdata = '0;
         endcase
      end
   end

endmodule

// File: serial_unit_top.sv
`timescale 1ns/1ps

module serial_unit_top (
   input  logic                          i_clk,
   input  logic                          i_rst,
   input  logic                          i_psel,
   input  logic                          i_penable,
   input  logic                          i_pwrite,
   input  logic [serial_pkg::APB_AW-1:0] i_paddr,
   input  serial_pkg::word_t             i_pwdata,
   output serial_pkg::word_t             o_prdata,
   output logic                          o_pslverr,
   output logic                          o_irq
);

   logic                 start;
   serial_pkg::cmd_t     cmd;
   logic                 busy;
   logic                 done;
   logic                 trap;
   serial_pkg::seq_ctl_t ctl;
   logic                 sh_ready;
   logic                 rs1_bit;
   logic                 rs2_bit;
   logic                 rd_bit;
   serial_pkg::reg_idx_t host_idx;
   logic                 host_we;
   serial_pkg::word_t    host_wdata;
   serial_pkg::word_t    host_rdata;

   serial_apb_regs i_serial_apb_regs (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_psel       (i_psel),
      .i_penable    (i_penable),
      .i_pwrite     (i_pwrite),
      .i_paddr      (i_paddr),
      .i_pwdata     (i_pwdata),
      .o_prdata     (o_prdata),
      .o_pslverr    (o_pslverr),
      .o_irq        (o_irq),
      .o_start      (start),
      .o_cmd        (cmd),
      .i_busy       (busy),
      .i_done       (done),
      .i_trap       (trap),
      .o_host_idx   (host_idx),
      .o_host_we    (host_we),
      .o_host_wdata (host_wdata),
      .i_host_rdata (host_rdata)
   );

   serial_state i_serial_state (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_start    (start),
      .i_cmd      (cmd),
      .i_sh_ready (sh_ready),
      .o_ctl      (ctl),
      .o_busy     (busy),
      .o_done     (done),
      .o_trap     (trap)
   );

   // the alu sits next to the sequencer that steers it.
   serial_alu i_serial_alu (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_ctl      (ctl),
      .i_op       (cmd.op),
      .i_rs1_bit  (rs1_bit),
      .i_rs2_bit  (rs2_bit),
      .o_rd_bit   (rd_bit),
      .o_sh_ready (sh_ready)
   );

   serial_rf i_serial_rf (
      .i_clk        (i_clk),
      .i_rst        (i_rst),
      .i_ctl        (ctl),
      .i_rs1        (cmd.rs1),
      .i_rs2        (cmd.rs2),
      .i_rd         (cmd.rd),
      .i_rd_bit     (rd_bit),
      .o_rs1_bit    (rs1_bit),
      .o_rs2_bit    (rs2_bit),
      .i_host_idx   (host_idx),
      .i_host_we    (host_we),
      .i_host_wdata (host_wdata),
      .o_host_rdata (host_rdata)
   );

endmodule

// File: serial_unit_asserts.sv
`timescale 1ns/1ps

module serial_unit_asserts (
   input logic                   i_clk,
   input logic                   i_rst,
   input logic                   i_start,
   input serial_pkg::ctl_state_t i_state,
   input serial_pkg::cnt_t       i_cnt,
   input logic                   i_busy,
   input logic                   i_done,
   input logic                   i_trap
);

   int assert_errors = 0;  // failed assertion count.

   idle_after_reset: assert property (@(posedge i_clk)
      i_rst |=> (i_state == serial_pkg::ST_IDLE))
      else begin
         $error("sequencer not idle after reset");
         assert_errors++;
      end

   done_trap_excl: assert property (@(posedge i_clk) disable iff (i_rst)
      !(i_done && i_trap))
      else begin
         $error("done and trap strobes high together");
         assert_errors++;
      end

   // busy only drops once the done or trap strobe has been seen.
   busy_holds: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_start || (i_busy && !i_done && !i_trap)) |=> i_busy)
      else begin
         $error("busy dropped before done or trap");
         assert_errors++;
      end

   cnt_idle_zero: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_state == serial_pkg::ST_IDLE) |-> (i_cnt == '0))
      else begin
         $error("bit counter not zero while idle");
         assert_errors++;
      end

endmodule

bind serial_state serial_unit_asserts i_serial_unit_asserts (
   .i_clk   (i_clk),
   .i_rst   (i_rst),
   .i_start (i_start),
   .i_state (state),
   .i_cnt   (cnt),
   .i_busy  (o_busy),
   .i_done  (o_done),
   .i_trap  (o_trap)
);

// File: tb_serial_unit.sv
`timescale 1ns/1ps

module tb_serial_unit;

   localparam int POLL_MAX = 60;  // status reads before a wait gives up.

   typedef struct packed {
      serial_pkg::op_code_t op;
      serial_pkg::reg_idx_t rd;
      serial_pkg::reg_idx_t rs1;
      serial_pkg::reg_idx_t rs2;
      serial_pkg::word_t    a;
      serial_pkg::word_t    b;
      serial_pkg::word_t    fill;  // preset of rd.
      serial_pkg::word_t    exp;
      logic                 ien;
      logic                 poke;  // hit the bus while busy.
   } row_t;

   logic                          clk;
   logic                          rst;
   logic                          psel;
   logic                          penable;
   logic                          pwrite;
   logic [serial_pkg::APB_AW-1:0] paddr;
   serial_pkg::word_t             pwdata;
   serial_pkg::word_t             prdata;
   logic                          pslverr;
   logic                          irq;

   row_t   rows[$];
   integer seed;
   int     errors;
   int     timeouts;

   serial_unit_top i_serial_unit_top (
      .i_clk     (clk),
      .i_rst     (rst),
      .i_psel    (psel),
      .i_penable (penable),
      .i_pwrite  (pwrite),
      .i_paddr   (paddr),
      .i_pwdata  (pwdata),
      .o_prdata  (prdata),
      .o_pslverr (pslverr),
      .o_irq     (irq)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   ////////////////////
   // reference model
   ////////////////////
   function automatic serial_pkg::word_t expected_result(input serial_pkg::op_code_t op,
                                                         input serial_pkg::word_t a,
                                                         input serial_pkg::word_t b);
      case (op)
         serial_pkg::OP_ADD: return a + b;
         serial_pkg::OP_SUB: return a - b;
         serial_pkg::OP_AND: return a & b;
         serial_pkg::OP_OR:  return a | b;
         serial_pkg::OP_XOR: return a ^ b;
         serial_pkg::OP_SLT: return {31'd0, ($signed(a) < $signed(b))};
         serial_pkg::OP_SLL: return a << b[4:0];
         default:            return a >> b[4:0];  // srl.
      endcase
   endfunction

   function automatic serial_pkg::reg_idx_t pick_reg(input int r);
      return serial_pkg::reg_idx_t'(1 + (r & 32'h7fff_ffff) % 7);  // 1 to 7.
   endfunction

   task automatic add_row(input serial_pkg::op_code_t op, input serial_pkg::reg_idx_t rd,
                          input serial_pkg::reg_idx_t rs1, input serial_pkg::reg_idx_t rs2,
                          input serial_pkg::word_t a, input serial_pkg::word_t b,
                          input logic ien, input logic poke);
      row_t r;
      r.op   = op;
      r.rd   = rd;
      r.rs1  = rs1;
      r.rs2  = rs2;
      r.a    = a;
      r.b    = (rs2 == rs1) ? a : b;  // one register holds both operands.
      r.fill = 32'h5a5a_0000 | rows.size();
      r.ien  = ien;
      r.poke = poke;
      if (rd == '0)
         r.exp = '0;
      else if (op[3])
         r.exp = r.fill;  // a trap leaves rd alone.
      else
         r.exp = expected_result(op, r.a, r.b);
      rows.push_back(r);
   endtask

   task automatic check(input serial_pkg::word_t got, input serial_pkg::word_t exp,
                        input string msg);
      if (got !== exp) begin
         $display("Fail at %0t: %s, got %h expected %h", $time, msg, got, exp);
         errors++;
      end
   endtask

   ////////////////////
   // apb driver
   ////////////////////
   task automatic apb_xfer(input logic wr, input logic [serial_pkg::APB_AW-1:0] addr,
                           input serial_pkg::word_t wdata,
                           output serial_pkg::word_t rdata, output logic err);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= wdata;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);  // middle of the access phase.
      rdata = prdata;
      err   = pslverr;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic write_reg(input logic [serial_pkg::APB_AW-1:0] addr,
                            input serial_pkg::word_t data);
      serial_pkg::word_t rdata;
      logic              err;
      apb_xfer(1'b1, addr, data, rdata, err);
      check({31'd0, err}, '0, $sformatf("pslverr on write to %h", addr));
   endtask

   task automatic read_reg(input logic [serial_pkg::APB_AW-1:0] addr,
                           output serial_pkg::word_t data);
      logic err;
      apb_xfer(1'b0, addr, '0, data, err);
      check({31'd0, err}, '0, $sformatf("pslverr on read of %h", addr));
   endtask

   task automatic expect_slverr(input logic wr, input logic [serial_pkg::APB_AW-1:0] addr,
                                input serial_pkg::word_t data, input string msg);
      serial_pkg::word_t rdata;
      logic              err;
      apb_xfer(wr, addr, data, rdata, err);
      check({31'd0, err}, 32'd1, msg);
   endtask

   // poll busy until the unit is idle.
   task automatic wait_idle();
      serial_pkg::word_t st;
      int                polls;
      st    = 32'd1;
      polls = 0;
      while (st[0] && polls < POLL_MAX) begin
         read_reg(serial_pkg::ADDR_STATUS, st);
         polls++;
      end
      if (st[0]) begin
         $display("timeout at %0t: unit still busy after %0d status reads", $time, polls);
         timeouts++;
      end
   endtask

   task automatic run_row(input row_t r);
      serial_pkg::word_t rdata;
      logic              trap;
      trap = r.op[3];
      write_reg(serial_pkg::ADDR_CTRL, {31'd0, r.ien});
      write_reg(serial_pkg::ADDR_IDX, {29'd0, r.rd});
      write_reg(serial_pkg::ADDR_DATA, r.fill);
      write_reg(serial_pkg::ADDR_IDX, {29'd0, r.rs1});
      write_reg(serial_pkg::ADDR_DATA, r.a);
      write_reg(serial_pkg::ADDR_IDX, {29'd0, r.rs2});
      write_reg(serial_pkg::ADDR_DATA, r.b);
      write_reg(serial_pkg::ADDR_CMD, {17'd0, r.rs2, 1'b0, r.rs1, 1'b0, r.rd, r.op});
      if (r.poke) begin
         expect_slverr(1'b1, serial_pkg::ADDR_CMD, 32'h0000_0077, "CMD write while busy");
         expect_slverr(1'b0, serial_pkg::ADDR_DATA, '0, "DATA read while busy");
         expect_slverr(1'b1, serial_pkg::ADDR_DATA, 32'hffff_ffff, "DATA write while busy");
      end
      wait_idle();
      read_reg(serial_pkg::ADDR_STATUS, rdata);
      check(rdata, {29'd0, trap, ~trap, 1'b0}, "status after command");
      @(negedge clk);
      check({31'd0, irq}, {31'd0, r.ien & ~trap}, "irq after command");
      write_reg(serial_pkg::ADDR_STATUS, 32'h6);  // clear done and trap.
      @(negedge clk);
      check({31'd0, irq}, '0, "irq after clearing done");
      read_reg(serial_pkg::ADDR_STATUS, rdata);
      check(rdata, '0, "status after clear");
      write_reg(serial_pkg::ADDR_IDX, {29'd0, r.rd});
      read_reg(serial_pkg::ADDR_DATA, rdata);
      check(rdata, r.exp, $sformatf("result of op %0d into r%0d", r.op, r.rd));
   endtask

   ////////////////////
   // main sequence
   ////////////////////
   initial begin
      serial_pkg::word_t    rdata;
      serial_pkg::word_t    rnd_a;
      serial_pkg::word_t    rnd_b;
      serial_pkg::word_t    rnd_w;
      serial_pkg::reg_idx_t rnd_rd;
      serial_pkg::reg_idx_t rnd_rs1;
      serial_pkg::reg_idx_t rnd_rs2;
      int                   n_assert;
      rst      = 1'b1;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      paddr    = '0;
      pwdata   = '0;
      errors   = 0;
      timeouts = 0;
      seed     = 13399;
      repeat (16) @(posedge clk);
      rst <= 1'b0;

      read_reg(serial_pkg::ADDR_STATUS, rdata);
      check(rdata, '0, "status after reset");
      read_reg(serial_pkg::ADDR_CTRL, rdata);
      check(rdata, '0, "interrupt enable after reset");
      @(negedge clk);
      check({31'd0, irq}, '0, "irq after reset");

      // register 0 ignores the host.
      write_reg(serial_pkg::ADDR_IDX, '0);
      write_reg(serial_pkg::ADDR_DATA, 32'h1234_5678);
      read_reg(serial_pkg::ADDR_DATA, rdata);
      check(rdata, '0, "register 0 after host write");
      expect_slverr(1'b0, 5'h14, '0, "read of unmapped address");

      add_row(serial_pkg::OP_ADD, 3'd3, 3'd1, 3'd2, 32'hffff_ffff, 32'h1, 1'b1, 1'b0);
      add_row(serial_pkg::OP_SUB, 3'd4, 3'd1, 3'd2, 32'h0, 32'h1, 1'b0, 1'b0);
      add_row(serial_pkg::OP_AND, 3'd5, 3'd6, 3'd7, 32'hf0f0_f0f0, 32'hff00_ff00, 1'b0, 1'b0);
      add_row(serial_pkg::OP_OR,  3'd6, 3'd1, 3'd2, 32'hf0f0_f0f0, 32'h0f00_ff00, 1'b1, 1'b0);
      add_row(serial_pkg::OP_XOR, 3'd7, 3'd1, 3'd2, 32'haaaa_5555, 32'hffff_0000, 1'b0, 1'b0);
      add_row(serial_pkg::OP_ADD, 3'd1, 3'd1, 3'd2, 32'h7fff_ffff, 32'h1, 1'b0, 1'b0);
      add_row(serial_pkg::OP_SLT, 3'd3, 3'd1, 3'd2, 32'h8000_0000, 32'h1, 1'b1, 1'b0);
      add_row(serial_pkg::OP_SLT, 3'd3, 3'd1, 3'd2, 32'h1, 32'h8000_0000, 1'b0, 1'b0);
      add_row(serial_pkg::OP_SLT, 3'd3, 3'd2, 3'd2, 32'hffff_fffe, 32'h0, 1'b0, 1'b0);
      add_row(serial_pkg::OP_SLL, 3'd4, 3'd1, 3'd2, 32'h8000_0001, 32'd31, 1'b0, 1'b0);
      add_row(serial_pkg::OP_SLL, 3'd4, 3'd1, 3'd2, 32'h1234_5678, 32'h20, 1'b0, 1'b0);
      add_row(serial_pkg::OP_SRL, 3'd5, 3'd1, 3'd2, 32'h8000_0001, 32'd4, 1'b1, 1'b0);
      add_row(serial_pkg::OP_ADD, 3'd0, 3'd1, 3'd2, 32'h1111_1111, 32'h2222_2222, 1'b0, 1'b0);
      add_row(4'hb, 3'd5, 3'd1, 3'd2, 32'h3, 32'h4, 1'b1, 1'b0);
      add_row(4'hf, 3'd6, 3'd3, 3'd4, 32'h5, 32'h6, 1'b0, 1'b0);
      add_row(serial_pkg::OP_SUB, 3'd7, 3'd2, 3'd3, 32'h0000_1000, 32'h0000_2001, 1'b0, 1'b1);
      add_row(serial_pkg::OP_SRL, 3'd2, 3'd2, 3'd3, 32'hdead_beef, 32'd13, 1'b1, 1'b1);
      for (int i = 0; i < 16; i++) begin
         rnd_w   = $random(seed);
         rnd_rd  = pick_reg($random(seed));
         rnd_rs1 = pick_reg($random(seed));
         rnd_rs2 = pick_reg($random(seed));
         rnd_a   = $random(seed);
         rnd_b   = $random(seed);
         add_row({1'b0, rnd_w[2:0]}, rnd_rd, rnd_rs1, rnd_rs2, rnd_a, rnd_b,
                 rnd_w[8], 1'b0);
      end

      foreach (rows[i])
         run_row(rows[i]);

      n_assert = i_serial_unit_top.i_serial_state.i_serial_unit_asserts.assert_errors;
      $display("errors: %0d check failures, %0d timeouts, %0d assertion failures",
               errors, timeouts, n_assert);
      if (errors == 0 && timeouts == 0 && n_assert == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

// File: tb.f
serial_pkg.sv
serial_state.sv
serial_alu.sv
serial_rf.sv
serial_apb_regs.sv
serial_unit_top.sv
serial_unit_asserts.sv
tb_serial_unit.sv

// File: Bender.yml
package:
  name: serial_unit

sources:
  - serial_pkg.sv
  - serial_state.sv
  - serial_alu.sv
  - serial_rf.sv
  - serial_apb_regs.sv
  - serial_unit_top.sv
  - target: test
    files:
      - serial_unit_asserts.sv
      - tb_serial_unit.sv
